/* include/msx_consts.svh */
`ifndef MSX_CONSTS_SVH
`define MSX_CONSTS_SVH

// SDRAM address width in bytes, 128 MB
`define MSX_RAM_AW 27

// 16K page, address bits inside one page
`define MSX_PAGE_AW 14

// Primary slots of the machine
`define MSX_SLOTS 4

// Layout table, slot x subslot x page
`define MSX_LAYOUT_DEPTH 64

// RAM lookup entries
`define MSX_RAM_LUT_DEPTH 16

// Width of one configuration word, same as a RAM lookup entry
`define MSX_CFG_W 44

// Secondary slot register sits at the top of page 3
`define MSX_EXP_ADDR 16'hFFFF

`endif

/* source/msx_bus_pkg.sv */
package msx_bus_pkg;

    // CPU cycle as seen by the slot logic
    typedef enum logic [1:0] {
        op_idle,   // No strobe this cycle
        op_read,
        op_write
    } bus_op_t;

    // Secondary slot register, one 2-bit subslot per 16K page
    // Field 0 is page 0 (0000-3FFF), field 3 is page 3
    typedef logic [3:0][1:0] subslot_reg_t;

endpackage

/* source/msx_cfg_pkg.sv */
package msx_cfg_pkg;

`include "msx_consts.svh"

    // Mapper kinds supported by bank_mapper
    typedef enum logic [1:0] {
        map_empty,   // Nothing mapped, no chip enable
        map_plain,   // Linear ROM or RAM
        map_ascii8,  // Four 8K banks
        map_ascii16  // Two 16K banks
    } mapper_t;

    // One layout entry, selected by slot, subslot and page
    typedef struct packed {
        mapper_t    mapper;
        logic [3:0] ref_ram;     // Index into the RAM lookup
        logic       cart_num;    // Bank register set
        logic [1:0] offset_ram;  // First page of the image
    } block_t;

    // RAM lookup entry
    typedef struct packed {
        logic [`MSX_RAM_AW-1:0] addr;  // Base in SDRAM
        logic [15:0]            size;  // In 16K blocks, power of two
        logic                   ro;    // Read only
    } ram_entry_t;

    // What a configuration write lands in
    typedef enum logic [1:0] {
        cfg_layout,
        cfg_ram,
        cfg_expand
    } cfg_target_t;

endpackage

/* source/slot_expander.sv */
`include "msx_consts.svh"

module slot_expander (
    input  logic                      clk,
    input  logic                      rst,
    input  msx_bus_pkg::bus_op_t      op,
    input  logic [15:0]               cpu_addr,
    input  logic [7:0]                cpu_wdata,
    input  logic                      slot_hit,        // This primary slot is active
    input  logic                      cfg_expand_we,   // Config write for this slot
    input  logic                      cfg_expand_bit,
    output msx_bus_pkg::subslot_reg_t sub_reg,
    output logic                      expanded
);

    logic reg_addr_hit;
    logic reg_we;

    assign reg_addr_hit = (cpu_addr == `MSX_EXP_ADDR);

    // Only an expanded slot owns FFFF
    assign reg_we = (op == msx_bus_pkg::op_write) && reg_addr_hit && slot_hit && expanded;

    // Expanded flag comes from the configuration port
    always_ff @(posedge clk) begin
        if (rst) begin
            expanded <= 1'b0;
        end else if (cfg_expand_we) begin
            expanded <= cfg_expand_bit;
        end
    end

    // Secondary slot register
    always_ff @(posedge clk) begin
        if (rst) begin
            sub_reg <= '0;               // All pages on subslot 0
        end else if (reg_we) begin
            sub_reg <= cpu_wdata;        // Visible from next cycle
        end
    end

endmodule

/* source/expander_select.sv */
`include "msx_consts.svh"

module expander_select (
    input  logic [1:0]                active_slot,
    input  msx_bus_pkg::subslot_reg_t sub_regs [`MSX_SLOTS],
    input  logic [`MSX_SLOTS-1:0]     expanded,
    input  logic [1:0]                page,            // cpu_addr[15:14]
    input  logic                      exp_access,      // Read of FFFF this cycle
    output logic [1:0]                active_subslot,
    output logic [7:0]                exp_data,
    output logic                      exp_rq
);

    msx_bus_pkg::subslot_reg_t sel_reg;
    logic                      sel_expanded;

    // Register and flag of the active primary slot
    assign sel_reg      = sub_regs[active_slot];
    assign sel_expanded = expanded[active_slot];

    // Non expanded slot behaves as subslot 0
    assign active_subslot = sel_expanded ? sel_reg[page] : 2'd0;

    // Read back is inverted, as on real hardware
    assign exp_data = ~sel_reg;

    // Takes the data bus only for an expanded slot
    assign exp_rq = sel_expanded && exp_access;

endmodule

/* source/layout_lookup.sv */
`include "msx_consts.svh"

module layout_lookup (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cfg_we,
    input  msx_cfg_pkg::cfg_target_t   cfg_target,
    input  logic [5:0]                 cfg_index,
    input  logic [`MSX_CFG_W-1:0]      cfg_value,
    input  logic [5:0]                 layout_id,      // {slot, subslot, page}
    output msx_cfg_pkg::block_t        active_block,
    output msx_cfg_pkg::ram_entry_t    active_ram
);

    localparam int BLOCK_W = $bits(msx_cfg_pkg::block_t);
    localparam int RAM_W   = $bits(msx_cfg_pkg::ram_entry_t);

    // Table storage
    msx_cfg_pkg::block_t     layout  [`MSX_LAYOUT_DEPTH];
    msx_cfg_pkg::ram_entry_t ram_lut [`MSX_RAM_LUT_DEPTH];

    logic layout_we;
    logic ram_we;

    assign layout_we = cfg_we && (cfg_target == msx_cfg_pkg::cfg_layout);
    assign ram_we    = cfg_we && (cfg_target == msx_cfg_pkg::cfg_ram);

    // Layout entries
    // Zero is map_empty, so nothing is enabled after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `MSX_LAYOUT_DEPTH; i++) begin
                layout[i] <= '0;
            end
        end else if (layout_we) begin
            layout[cfg_index] <= msx_cfg_pkg::block_t'(cfg_value[BLOCK_W-1:0]);
        end
    end

    // RAM lookup entries
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `MSX_RAM_LUT_DEPTH; i++) begin
                ram_lut[i] <= '0;
            end
        end else if (ram_we) begin
            // Low 4 bits of the index only
            ram_lut[cfg_index[3:0]] <= msx_cfg_pkg::ram_entry_t'(cfg_value[RAM_W-1:0]);
        end
    end

    // Two level read, layout first then its RAM entry
    assign active_block = layout[layout_id];
    assign active_ram   = ram_lut[active_block.ref_ram];

endmodule

/* source/bank_mapper.sv */
`include "msx_consts.svh"

module bank_mapper (
    input  logic                    clk,
    input  logic                    rst,
    input  msx_bus_pkg::bus_op_t    op,
    input  logic [15:0]             cpu_addr,
    input  logic [7:0]              cpu_wdata,
    input  msx_cfg_pkg::block_t     active_block,
    input  msx_cfg_pkg::ram_entry_t active_ram,
    output logic [`MSX_RAM_AW-1:0]  offset,         // Byte offset from the RAM base
    output logic                    map_cs,
    output logic                    map_write_ok
);

    localparam int SIZE_BITS = `MSX_RAM_AW - `MSX_PAGE_AW;

    // Four bank registers per cartridge
    logic [7:0] banks [2][4];

    logic                   cart;
    logic [1:0]             page;
    logic [1:0]             page_rel;       // Page inside the ROM image
    logic [1:0]             a8_idx;         // 8K window 4000/6000/8000/A000
    logic [1:0]             a16_idx;        // 16K window 4000/8000
    logic                   bank_wr;
    logic [`MSX_RAM_AW-1:0] raw_offset;
    logic [`MSX_RAM_AW-1:0] size_bytes;

    assign cart     = active_block.cart_num;
    assign page     = cpu_addr[15:14];
    assign page_rel = page - active_block.offset_ram;
    assign a8_idx   = 2'(cpu_addr[15:13] - 3'd2);
    assign a16_idx  = page - 2'd1;
    assign bank_wr  = (op == msx_bus_pkg::op_write);

    // Bank register writes
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int c = 0; c < 2; c++) begin
                for (int i = 0; i < 4; i++) begin
                    banks[c][i] <= 8'(i);   // Ascending pages
                end
            end
        end else if (bank_wr) begin
            case (active_block.mapper)
                msx_cfg_pkg::map_ascii8: begin
                    if (cpu_addr[15:13] == 3'b011) begin   // 6000-7FFF
                        banks[cart][cpu_addr[12:11]] <= cpu_wdata;
                    end
                end
                msx_cfg_pkg::map_ascii16: begin
                    if (cpu_addr[15:11] == 5'b01100) begin        // 6000-67FF
                        banks[cart][0] <= cpu_wdata;
                    end else if (cpu_addr[15:11] == 5'b01110) begin // 7000-77FF
                        banks[cart][1] <= cpu_wdata;
                    end
                end
                default: ;
            endcase
        end
    end

    // Offset before the size wrap
    always_comb begin
        case (active_block.mapper)
            msx_cfg_pkg::map_plain:
                raw_offset = `MSX_RAM_AW'({page_rel, cpu_addr[13:0]});
            msx_cfg_pkg::map_ascii8:
                raw_offset = `MSX_RAM_AW'({banks[cart][a8_idx], cpu_addr[12:0]});
            msx_cfg_pkg::map_ascii16:
                raw_offset = `MSX_RAM_AW'({banks[cart][a16_idx], cpu_addr[13:0]});
            default:
                raw_offset = '0;
        endcase
    end

    // Image size in bytes
    // Zero size gives an all ones mask and no wrap
    assign size_bytes = {active_ram.size[SIZE_BITS-1:0], {`MSX_PAGE_AW{1'b0}}};
    assign offset     = raw_offset & (size_bytes - 1'b1);

    assign map_cs       = (active_block.mapper != msx_cfg_pkg::map_empty);
    assign map_write_ok = (active_block.mapper == msx_cfg_pkg::map_plain) && !active_ram.ro;

endmodule

/* source/msx_slots.sv */
`include "msx_consts.svh"

module msx_slots (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cpu_req,       // One cycle strobe
    input  logic                     cpu_rnw,
    input  logic [15:0]              cpu_addr,
    input  logic [7:0]               cpu_wdata,
    input  logic [1:0]               active_slot,
    input  logic                     cfg_we,
    input  msx_cfg_pkg::cfg_target_t cfg_target,
    input  logic [5:0]               cfg_index,
    input  logic [`MSX_CFG_W-1:0]    cfg_value,
    input  logic [7:0]               ram_dout,
    output logic [`MSX_RAM_AW-1:0]   ram_addr,
    output logic [7:0]               ram_din,
    output logic                     ram_rnw,
    output logic                     sdram_ce,
    output logic [7:0]               data,
    output logic                     data_oe_rq     // Slot logic drives the CPU bus
);

    msx_bus_pkg::bus_op_t      op;
    msx_bus_pkg::subslot_reg_t sub_regs [`MSX_SLOTS];
    logic [`MSX_SLOTS-1:0]     expanded;
    logic [`MSX_SLOTS-1:0]     slot_hit;
    logic                      cfg_exp_we;
    logic                      exp_hit;         // Address is FFFF
    logic                      exp_access;
    logic                      exp_wr_blk;      // Subslot register write, not memory
    logic [1:0]                active_subslot;
    logic [7:0]                exp_data;
    logic                      exp_rq;
    msx_cfg_pkg::block_t       active_block;
    msx_cfg_pkg::ram_entry_t   active_ram;
    logic [`MSX_RAM_AW-1:0]    offset;
    logic                      map_cs;
    logic                      map_write_ok;

    // Bus op decode
    assign op = !cpu_req ? msx_bus_pkg::op_idle :
                cpu_rnw  ? msx_bus_pkg::op_read : msx_bus_pkg::op_write;

    assign cfg_exp_we = cfg_we && (cfg_target == msx_cfg_pkg::cfg_expand);
    assign exp_hit    = (cpu_addr == `MSX_EXP_ADDR);
    assign exp_access = exp_hit && (op == msx_bus_pkg::op_read);
    assign exp_wr_blk = exp_hit && (op == msx_bus_pkg::op_write) && expanded[active_slot];

    // One expander per primary slot
    for (genvar gi = 0; gi < `MSX_SLOTS; gi++) begin : g_slot
        assign slot_hit[gi] = (active_slot == 2'(gi));

        slot_expander u_exp (
            .clk            (clk),
            .rst            (rst),
            .op             (op),
            .cpu_addr       (cpu_addr),
            .cpu_wdata      (cpu_wdata),
            .slot_hit       (slot_hit[gi]),
            .cfg_expand_we  (cfg_exp_we && (cfg_index[1:0] == 2'(gi))),
            .cfg_expand_bit (cfg_value[0]),
            .sub_reg        (sub_regs[gi]),
            .expanded       (expanded[gi])
        );
    end

    expander_select u_sel (
        .active_slot    (active_slot),
        .sub_regs       (sub_regs),
        .expanded       (expanded),
        .page           (cpu_addr[15:14]),
        .exp_access     (exp_access),
        .active_subslot (active_subslot),
        .exp_data       (exp_data),
        .exp_rq         (exp_rq)
    );

    layout_lookup u_lut (
        .clk          (clk),
        .rst          (rst),
        .cfg_we       (cfg_we),
        .cfg_target   (cfg_target),
        .cfg_index    (cfg_index),
        .cfg_value    (cfg_value),
        .layout_id    ({active_slot, active_subslot, cpu_addr[15:14]}),
        .active_block (active_block),
        .active_ram   (active_ram)
    );

    bank_mapper u_map (
        .clk          (clk),
        .rst          (rst),
        .op           (op),
        .cpu_addr     (cpu_addr),
        .cpu_wdata    (cpu_wdata),
        .active_block (active_block),
        .active_ram   (active_ram),
        .offset       (offset),
        .map_cs       (map_cs),
        .map_write_ok (map_write_ok)
    );

    assign ram_addr = active_ram.addr + offset;    // Base plus mapper offset
    assign ram_din  = cpu_wdata;

    // Read only entries and non plain mappers never write
    assign ram_rnw = !((op == msx_bus_pkg::op_write) && map_write_ok);

    assign sdram_ce = map_cs && (op != msx_bus_pkg::op_idle) && !exp_rq && !exp_wr_blk;

    // Subslot read back has priority over memory
    assign data       = exp_rq ? exp_data : ram_dout;
    assign data_oe_rq = exp_rq;

endmodule

/* testbench/tb_clock.sv */
module tb_clock #(
    parameter int PERIOD = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;                     // First edge is a rising one
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

/* testbench/msx_slots_tb.sv */
`include "msx_consts.svh"

module msx_slots_tb;

    localparam int RESET_CYCLES    = 10;
    localparam int DIRECTED_CYCLES = 80;    // Tests 1 to 5 take under 60
    localparam int RANDOM_CYCLES   = 300;
    localparam int TIMEOUT_CYCLES  = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + 100;

    logic                     clk;
    logic                     rst;
    logic                     cpu_req;
    logic                     cpu_rnw;
    logic [15:0]              cpu_addr;
    logic [7:0]               cpu_wdata;
    logic [1:0]               active_slot;
    logic                     cfg_we;
    msx_cfg_pkg::cfg_target_t cfg_target;
    logic [5:0]               cfg_index;
    logic [`MSX_CFG_W-1:0]    cfg_value;
    logic [7:0]               ram_dout;
    logic [`MSX_RAM_AW-1:0]   ram_addr;
    logic [7:0]               ram_din;
    logic                     ram_rnw;
    logic                     sdram_ce;
    logic [7:0]               data;
    logic                     data_oe_rq;

    // Model state, mirrors the tables and registers
    msx_cfg_pkg::block_t     m_layout [`MSX_LAYOUT_DEPTH];
    msx_cfg_pkg::ram_entry_t m_ram    [`MSX_RAM_LUT_DEPTH];
    logic [7:0]              m_sub    [`MSX_SLOTS];
    logic [`MSX_SLOTS-1:0]   m_expanded;
    logic [7:0]              m_banks  [8];          // Index is cart*4 + register
    logic [7:0]              sdram_mem [256];       // SDRAM read data stand-in

    // Expected outputs for the current cycle
    logic [`MSX_RAM_AW-1:0]  exp_addr;
    logic                    exp_ce;
    logic                    exp_rnw;
    logic                    exp_oe;
    logic [7:0]              exp_data;
    logic [7:0]              exp_din;               // Write data toward the SDRAM

    logic   check_en    = 1'b0;
    int     check_count = 0;
    int     error_count = 0;
    int     cycle_count = 0;
    integer seed        = 32'h3fb;
    string  test_name   = "reset";

    tb_clock #(.PERIOD(8)) u_clk (.clk(clk));

    msx_slots UUT (
        .clk         (clk),
        .rst         (rst),
        .cpu_req     (cpu_req),
        .cpu_rnw     (cpu_rnw),
        .cpu_addr    (cpu_addr),
        .cpu_wdata   (cpu_wdata),
        .active_slot (active_slot),
        .cfg_we      (cfg_we),
        .cfg_target  (cfg_target),
        .cfg_index   (cfg_index),
        .cfg_value   (cfg_value),
        .ram_dout    (ram_dout),
        .ram_addr    (ram_addr),
        .ram_din     (ram_din),
        .ram_rnw     (ram_rnw),
        .sdram_ce    (sdram_ce),
        .data        (data),
        .data_oe_rq  (data_oe_rq)
    );

    function automatic logic [5:0] layout_idx(input logic [1:0] slot, sub, page);
        return {slot, sub, page};
    endfunction

    function automatic logic [`MSX_CFG_W-1:0] block_word(input msx_cfg_pkg::mapper_t mapper,
            input logic [3:0] ref_ram, input logic cart, input logic [1:0] first_page);
        return `MSX_CFG_W'({mapper, ref_ram, cart, first_page});
    endfunction

    function automatic logic [`MSX_CFG_W-1:0] ram_word(input logic [`MSX_RAM_AW-1:0] base,
            input logic [15:0] size, input logic ro);
        return {base, size, ro};
    endfunction

    function automatic logic [7:0] mem_byte(input logic [`MSX_RAM_AW-1:0] a);
        logic [7:0] idx;
        idx = a[7:0] ^ a[15:8] ^ a[23:16] ^ {5'd0, a[26:24]};   // Fold of the whole address
        return sdram_mem[idx];
    endfunction

    // Layout entry seen by the CPU for this slot and address
    function automatic msx_cfg_pkg::block_t block_for(input logic [15:0] addr,
            input logic [1:0] slot);
        logic [1:0] page;
        logic [1:0] sub;
        page = addr[15:14];
        sub  = m_expanded[slot] ? m_sub[slot][2*page +: 2] : 2'd0;   // Unexpanded is subslot 0
        return m_layout[{slot, sub, page}];
    endfunction

    function automatic void predict_access(input logic req, rnw, input logic [15:0] addr,
            input logic [1:0] slot, output logic [`MSX_RAM_AW-1:0] p_addr,
            output logic p_ce, p_rnw, p_oe, output logic [7:0] p_data);
        msx_cfg_pkg::block_t     blk;
        msx_cfg_pkg::ram_entry_t ent;
        logic [1:0]              rel;
        logic [2:0]              win8;
        logic [1:0]              win16;
        logic                    is_ff;
        longint                  off;
        blk   = block_for(addr, slot);
        ent   = m_ram[blk.ref_ram];
        rel   = addr[15:14] - blk.offset_ram;       // Page inside the image
        win8  = addr[15:13] - 3'd2;                 // 8K window from 4000
        win16 = addr[15:14] - 2'd1;                 // 16K window from 4000
        is_ff = (addr == `MSX_EXP_ADDR);
        case (blk.mapper)
            msx_cfg_pkg::map_plain:   off = longint'(rel) * 16384 + addr[13:0];
            msx_cfg_pkg::map_ascii8:  off = longint'(m_banks[{blk.cart_num, win8[1:0]}]) * 8192
                                            + addr[12:0];
            msx_cfg_pkg::map_ascii16: off = longint'(m_banks[{blk.cart_num, win16}]) * 16384
                                            + addr[13:0];
            default:                  off = 0;
        endcase
        if (ent.size != 0) begin
            off = off % (longint'(ent.size) * 16384);   // Wrap at image size
        end
        p_addr = `MSX_RAM_AW'(longint'(ent.addr) + off);
        p_oe   = req && rnw && is_ff && m_expanded[slot];
        p_ce   = (blk.mapper != msx_cfg_pkg::map_empty) && req && !p_oe
                 && !(!rnw && is_ff && m_expanded[slot]);   // Subslot write is not memory
        p_rnw  = !(req && !rnw && blk.mapper == msx_cfg_pkg::map_plain && !ent.ro);
        p_data = p_oe ? ~m_sub[slot] : mem_byte(p_addr);
    endfunction

    // State changes of one cycle, all from the state before it
    task automatic update_model(input logic req, rnw, input logic [15:0] addr,
            input logic [7:0] wdata, input logic [1:0] slot, input logic we,
            input msx_cfg_pkg::cfg_target_t target, input logic [5:0] idx,
            input logic [`MSX_CFG_W-1:0] value);
        msx_cfg_pkg::block_t blk;
        logic                wr;
        blk = block_for(addr, slot);
        wr  = req && !rnw;
        if (wr && blk.mapper == msx_cfg_pkg::map_ascii8 && addr >= 16'h6000 && addr <= 16'h7FFF)
            m_banks[{blk.cart_num, addr[12:11]}] = wdata;
        if (wr && blk.mapper == msx_cfg_pkg::map_ascii16) begin
            if (addr >= 16'h6000 && addr <= 16'h67FF)
                m_banks[{blk.cart_num, 2'd0}] = wdata;
            else if (addr >= 16'h7000 && addr <= 16'h77FF)
                m_banks[{blk.cart_num, 2'd1}] = wdata;
        end
        if (wr && addr == `MSX_EXP_ADDR && m_expanded[slot])
            m_sub[slot] = wdata;
        if (we && target == msx_cfg_pkg::cfg_layout)
            m_layout[idx] = msx_cfg_pkg::block_t'(value[$bits(msx_cfg_pkg::block_t)-1:0]);
        if (we && target == msx_cfg_pkg::cfg_ram)
            m_ram[idx[3:0]] = msx_cfg_pkg::ram_entry_t'(value);
        if (we && target == msx_cfg_pkg::cfg_expand)
            m_expanded[idx[1:0]] = value[0];
    endtask

    // One cycle of stimulus, driven on the falling edge
    task automatic drive_cycle(input logic req, rnw, input logic [15:0] addr,
            input logic [7:0] wdata, input logic [1:0] slot, input logic we,
            input msx_cfg_pkg::cfg_target_t target, input logic [5:0] idx,
            input logic [`MSX_CFG_W-1:0] value);
        @(negedge clk);
        cpu_req     = req;
        cpu_rnw     = rnw;
        cpu_addr    = addr;
        cpu_wdata   = wdata;
        active_slot = slot;
        cfg_we      = we;
        cfg_target  = target;
        cfg_index   = idx;
        cfg_value   = value;
        predict_access(req, rnw, addr, slot, exp_addr, exp_ce, exp_rnw, exp_oe, exp_data);
        exp_din  = wdata;                   // CPU byte is what lands in RAM
        ram_dout = mem_byte(exp_addr);      // SDRAM answers at the expected address
        update_model(req, rnw, addr, wdata, slot, we, target, idx, value);
        check_en = 1'b1;
    endtask

    task automatic cpu_read(input logic [1:0] slot, input logic [15:0] addr);
        drive_cycle(1'b1, 1'b1, addr, 8'h00, slot, 1'b0, msx_cfg_pkg::cfg_layout, 6'd0, '0);
    endtask

    task automatic cpu_write(input logic [1:0] slot, input logic [15:0] addr,
            input logic [7:0] wdata);
        drive_cycle(1'b1, 1'b0, addr, wdata, slot, 1'b0, msx_cfg_pkg::cfg_layout, 6'd0, '0);
    endtask

    task automatic write_config(input msx_cfg_pkg::cfg_target_t target, input logic [5:0] idx,
            input logic [`MSX_CFG_W-1:0] value);
        drive_cycle(1'b0, 1'b1, 16'h0000, 8'h00, 2'd0, 1'b1, target, idx, value);
    endtask

    task automatic report_mismatch(input string sig, input logic [31:0] expected,
            input logic [31:0] actual);
        error_count++;
        $display("Error in %s: %s expected 0x%0h actual 0x%0h", test_name, sig, expected, actual);
        $display("TEST FAILED");
        $fatal(1, "mismatch on %s", sig);
    endtask

    // Compare before the rising edge updates any state
    always @(posedge clk) begin
        if (check_en) begin
            check_count++;
            assert (sdram_ce === exp_ce) else report_mismatch("sdram_ce", exp_ce, sdram_ce);
            assert (!exp_ce || ram_addr === exp_addr)
                else report_mismatch("ram_addr", exp_addr, ram_addr);
            assert (ram_rnw === exp_rnw) else report_mismatch("ram_rnw", exp_rnw, ram_rnw);
            assert (!exp_ce || exp_rnw || ram_din === exp_din)
                else report_mismatch("ram_din", exp_din, ram_din);
            assert (data_oe_rq === exp_oe)
                else report_mismatch("data_oe_rq", exp_oe, data_oe_rq);
            assert (data === exp_data) else report_mismatch("data", exp_data, data);
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Error: the run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        logic [31:0] r_word;
        logic [15:0] r_addr;
        rst         = 1'b1;
        cpu_req     = 1'b0;
        cpu_rnw     = 1'b1;
        cpu_addr    = 16'h0000;
        cpu_wdata   = 8'h00;
        active_slot = 2'd0;
        cfg_we      = 1'b0;
        cfg_target  = msx_cfg_pkg::cfg_layout;
        cfg_index   = 6'd0;
        cfg_value   = '0;
        ram_dout    = 8'h00;
        m_expanded  = '0;
        for (int i = 0; i < `MSX_LAYOUT_DEPTH; i++) m_layout[i] = '0;
        for (int i = 0; i < `MSX_RAM_LUT_DEPTH; i++) m_ram[i] = '0;
        for (int i = 0; i < `MSX_SLOTS; i++) m_sub[i] = 8'h00;
        for (int i = 0; i < 8; i++) m_banks[i] = 8'(i % 4);    // Register i holds i
        for (int i = 0; i < 256; i++) sdram_mem[i] = 8'(i * 29 + 90);
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        test_name = "after_reset";          // All layouts empty
        cpu_read(2'd0, 16'h0000);
        cpu_read(2'd1, 16'h4000);
        cpu_write(2'd2, 16'h8000, 8'h55);
        cpu_read(2'd3, 16'hFFFF);

        test_name = "plain_rom_ram";
        write_config(msx_cfg_pkg::cfg_ram, 6'd0, ram_word(27'h010_0000, 16'd2, 1'b1));  // 32K ROM
        write_config(msx_cfg_pkg::cfg_ram, 6'd1, ram_word(27'h020_0000, 16'd4, 1'b0));  // 64K RAM
        write_config(msx_cfg_pkg::cfg_layout, layout_idx(0, 0, 1),
                     block_word(msx_cfg_pkg::map_plain, 4'd0, 1'b0, 2'd1));
        write_config(msx_cfg_pkg::cfg_layout, layout_idx(0, 0, 2),
                     block_word(msx_cfg_pkg::map_plain, 4'd0, 1'b0, 2'd1));
        for (int p = 0; p < 4; p++) begin
            write_config(msx_cfg_pkg::cfg_layout, layout_idx(3, 0, p),
                         block_word(msx_cfg_pkg::map_plain, 4'd1, 1'b0, 2'd0));
        end
        cpu_read(2'd0, 16'h4000);
        cpu_read(2'd0, 16'h7FFF);
        cpu_read(2'd0, 16'h8123);
        cpu_write(2'd0, 16'h5000, 8'hA5);   // ROM, no write
        cpu_read(2'd0, 16'hC000);           // Empty page
        cpu_write(2'd3, 16'h0000, 8'h11);
        cpu_write(2'd3, 16'hC321, 8'h22);
        cpu_read(2'd3, 16'h4321);

        test_name = "expanded_slot";
        write_config(msx_cfg_pkg::cfg_expand, 6'd3, `MSX_CFG_W'(1));
        write_config(msx_cfg_pkg::cfg_layout, layout_idx(3, 2, 1),
                     block_word(msx_cfg_pkg::map_plain, 4'd0, 1'b0, 2'd1));
        write_config(msx_cfg_pkg::cfg_layout, layout_idx(0, 0, 3),
                     block_word(msx_cfg_pkg::map_plain, 4'd1, 1'b0, 2'd0));
        cpu_read(2'd3, 16'h4000);           // Subslot 0, RAM
        cpu_write(2'd3, 16'hFFFF, 8'h08);   // Page 1 to subslot 2
        cpu_read(2'd3, 16'h4000);           // Now the ROM
        cpu_read(2'd3, 16'hFFFF);
        cpu_read(2'd3, 16'h0100);
        cpu_write(2'd0, 16'hFFFF, 8'h3C);   // Slot 0 plain RAM at FFFF
        cpu_read(2'd0, 16'hFFFF);

        test_name = "ascii_banks";
        write_config(msx_cfg_pkg::cfg_ram, 6'd2, ram_word(27'h040_0000, 16'd4, 1'b1));  // 64K
        write_config(msx_cfg_pkg::cfg_ram, 6'd3, ram_word(27'h080_0000, 16'd8, 1'b1));  // 128K
        for (int p = 1; p < 3; p++) begin
            write_config(msx_cfg_pkg::cfg_layout, layout_idx(1, 0, p),
                         block_word(msx_cfg_pkg::map_ascii8, 4'd2, 1'b0, 2'd0));
            write_config(msx_cfg_pkg::cfg_layout, layout_idx(2, 0, p),
                         block_word(msx_cfg_pkg::map_ascii16, 4'd3, 1'b1, 2'd0));
        end
        cpu_read(2'd1, 16'h4010);           // Reset banks
        cpu_write(2'd1, 16'h6000, 8'h05);
        cpu_write(2'd1, 16'h6800, 8'h01);
        cpu_write(2'd1, 16'h7000, 8'h09);   // Past 64K, wraps
        cpu_write(2'd1, 16'h7FFF, 8'h02);
        cpu_read(2'd1, 16'h4010);
        cpu_read(2'd1, 16'h6010);
        cpu_read(2'd1, 16'h8010);
        cpu_read(2'd1, 16'hA010);
        cpu_write(2'd2, 16'h6000, 8'h03);
        cpu_write(2'd2, 16'h7000, 8'h0A);   // Wraps at 128K
        cpu_write(2'd2, 16'h6800, 8'h07);   // Outside both windows
        cpu_read(2'd2, 16'h4123);
        cpu_read(2'd2, 16'h8123);

        test_name = "two_carts";
        for (int p = 1; p < 3; p++) begin
            write_config(msx_cfg_pkg::cfg_layout, layout_idx(3, 1, p),
                         block_word(msx_cfg_pkg::map_ascii8, 4'd2, 1'b1, 2'd0));
        end
        cpu_write(2'd3, 16'hFFFF, 8'h14);   // Pages 1 and 2 to subslot 1
        cpu_write(2'd3, 16'h6000, 8'h07);   // Cart 1 register 0
        cpu_read(2'd3, 16'h4000);
        cpu_read(2'd1, 16'h4000);           // Cart 0 untouched
        cpu_read(2'd2, 16'h4000);

        test_name = "random_mix";
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            r_word = $random(seed);
            r_addr = 16'($random(seed));
            if (r_word[2:0] == 3'd0) begin
                r_addr = `MSX_EXP_ADDR;     // Hit the subslot register often
            end
            drive_cycle(r_word[7:4] != 4'd0, r_word[8], r_addr, r_word[23:16], r_word[10:9],
                        1'b0, msx_cfg_pkg::cfg_layout, 6'd0, '0);
        end

        drive_cycle(1'b0, 1'b1, 16'h0000, 8'h00, 2'd0, 1'b0, msx_cfg_pkg::cfg_layout, 6'd0, '0);
        @(negedge clk);
        if (error_count == 0 && check_count > 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+include
source/msx_bus_pkg.sv
source/msx_cfg_pkg.sv
source/slot_expander.sv
source/expander_select.sv
source/layout_lookup.sv
source/bank_mapper.sv
source/msx_slots.sv
testbench/tb_clock.sv
testbench/msx_slots_tb.sv
